// File: design/ooo_pkg.sv
package ooo_pkg;

    // broadcast lanes coming in from the other functional units
    localparam int NUM_CDB_ENTRIES = 2;

    // entries in the ROB value table, indexed by rob_tag_t
    localparam int ROB_DEPTH = 16;

    // data and PC words
    typedef logic [31:0] rv32i_word;

    // ROB index, 0 is reserved for "no tag"
    typedef logic [3:0] rob_tag_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        none,
        jal,
        jalr
    } jmp_type_t;

    // source operand, either a value (valid) or a pending tag
    typedef struct packed {
        logic      valid;
        rob_tag_t  tag;
        rv32i_word value;
    } operand_t;

    // renamed instruction from the decoder
    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        jmp_type_t jmp_type;
        rv32i_word curr_pc;
        rob_tag_t  rob_idx;
        operand_t  rs1;
        operand_t  rs2;
    } alu_rs_t;

    typedef struct packed {
        logic      can_commit;
        rv32i_word value;
    } rob_data_t;

    typedef struct packed {
        logic      valid;
        rob_data_t reg_data;
    } rob_entry_t;

    typedef rob_entry_t [ROB_DEPTH-1:0] rob_arr_t;

    // one broadcast lane, tag 0 means idle
    typedef struct packed {
        rob_tag_t  tag;
        rv32i_word value;
        rv32i_word target_pc;
    } cdb_entry_t;

    typedef cdb_entry_t [NUM_CDB_ENTRIES-1:0] cdb_t;

endpackage

// File: design/alu.sv
`timescale 1ns/1ps

module alu
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      load_alu_i,
    input  alu_op_t   op_i,
    input  rv32i_word a_i,
    input  rv32i_word b_i,
    output rv32i_word f_o,
    output logic      ready_o
);

    rv32i_word  result;
    logic [4:0] shamt;

    // RV32I shifts only look at the low 5 bits
    assign shamt = b_i[4:0];

    always_comb begin
        unique case (op_i)
            alu_add:  result = a_i + b_i;
            alu_sub:  result = a_i - b_i;
            alu_sll:  result = a_i << shamt;
            alu_slt:  result = {31'b0, $signed(a_i) < $signed(b_i)};
            alu_sltu: result = {31'b0, a_i < b_i};
            alu_xor:  result = a_i ^ b_i;
            alu_srl:  result = a_i >> shamt;
            alu_sra:  result = rv32i_word'($signed(a_i) >>> shamt);
            alu_or:   result = a_i | b_i;
            alu_and:  result = a_i & b_i;
            default:  result = a_i + b_i;
        endcase
    end

    // result held until the next load
    always_ff @(posedge clk) begin
        if (load_alu_i) begin
            f_o <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= load_alu_i;
        end
    end

    // each launch is a single load pulse, so ready never stays up
    assert property (@(posedge clk) disable iff (reset_i)
        ready_o |-> !$past(ready_o))
        else $error("alu: ready_o high two cycles in a row");

endmodule

// File: design/rob_value_table.sv
`timescale 1ns/1ps

module rob_value_table
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      flush_i,
    input  logic      wr_en_i,
    input  rob_tag_t  wr_idx_i,
    input  rob_data_t wr_data_i,
    output rob_arr_t  rob_arr_o
);

    logic [ROB_DEPTH-1:0] valid_q;
    rob_data_t            data_q [ROB_DEPTH];

    // entry becomes valid on its completion write
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            data_q[wr_idx_i] <= wr_data_i;
        end
    end

    // flat view for the reservation station lookups
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rob_arr_o[i].valid    = valid_q[i];
            rob_arr_o[i].reg_data = data_q[i];
        end
    end

    // index 0 stands for "no tag" and is never allocated
    assert property (@(posedge clk) disable iff (reset_i)
        wr_en_i |-> wr_idx_i != '0)
        else $error("rob_value_table: write to reserved index 0");

endmodule

// File: design/alu_rs.sv
`timescale 1ns/1ps

module alu_rs
    import ooo_pkg::*;
#(
    parameter int RS_SIZE = 6
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  rob_arr_t                 rob_arr_i,
    input  cdb_t                     cdb_i,
    input  alu_rs_t                  issue_i,
    output cdb_entry_t [RS_SIZE-1:0] cdb_alu_o,
    output logic                     rs_full_o
);

    alu_rs_t          slot_q [RS_SIZE];
    logic [RS_SIZE-1:0] busy_q;
    logic [RS_SIZE-1:0] issued_q;
    logic [RS_SIZE-1:0] load_alu_q;

    logic [RS_SIZE-1:0] alloc_oh;
    logic [RS_SIZE-1:0] alloc_go;
    logic               free_found;
    logic [RS_SIZE-1:0] start;
    logic [RS_SIZE-1:0] done;
    logic [RS_SIZE-1:0] alu_ready;
    rv32i_word          alu_f      [RS_SIZE];
    rv32i_word          target_sum [RS_SIZE];

    // pick up a pending operand from the ROB table or a matching CDB lane
    function automatic operand_t resolve(operand_t opnd, rob_arr_t rob, cdb_t cdb);
        operand_t res;
        res = opnd;
        if (!opnd.valid) begin
            if (rob[opnd.tag].valid && rob[opnd.tag].reg_data.can_commit) begin
                res.valid = 1'b1;
                res.value = rob[opnd.tag].reg_data.value;
            end
            for (int j = 0; j < NUM_CDB_ENTRIES; j++) begin
                if (cdb[j].tag != '0 && cdb[j].tag == opnd.tag) begin
                    res.valid = 1'b1;
                    res.value = cdb[j].value;
                end
            end
        end
        return res;
    endfunction

    // lowest free slot wins
    always_comb begin
        alloc_oh   = '0;
        free_found = 1'b0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (!busy_q[i] && !free_found) begin
                alloc_oh[i] = 1'b1;
                free_found  = 1'b1;
            end
        end
    end

    assign alloc_go = (issue_i.valid && !flush_i) ? alloc_oh : '0;

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            start[i] = busy_q[i] && !issued_q[i] && slot_q[i].rs1.valid
                       && slot_q[i].rs2.valid;
            // ready only counts for a slot that actually launched its ALU
            done[i] = busy_q[i] && issued_q[i] && alu_ready[i];
            target_sum[i] = slot_q[i].rs1.value + slot_q[i].rs2.value;
        end
    end

    // slot contents and operand capture
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (alloc_go[i]) begin
                slot_q[i]     <= issue_i;
                slot_q[i].rs1 <= resolve(issue_i.rs1, rob_arr_i, cdb_i);
                slot_q[i].rs2 <= resolve(issue_i.rs2, rob_arr_i, cdb_i);
            end else if (busy_q[i]) begin
                slot_q[i].rs1 <= resolve(slot_q[i].rs1, rob_arr_i, cdb_i);
                slot_q[i].rs2 <= resolve(slot_q[i].rs2, rob_arr_i, cdb_i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            busy_q     <= '0;
            issued_q   <= '0;
            load_alu_q <= '0;
            cdb_alu_o  <= '0;
            rs_full_o  <= 1'b0;
        end else begin
            // full flag trails the allocation by a cycle
            rs_full_o <= &busy_q;
            for (int i = 0; i < RS_SIZE; i++) begin
                load_alu_q[i] <= start[i];
                cdb_alu_o[i]  <= '0;
                if (alloc_go[i]) begin
                    busy_q[i]   <= 1'b1;
                    issued_q[i] <= 1'b0;
                end
                if (start[i]) begin
                    issued_q[i] <= 1'b1;
                end
                // one-cycle broadcast, slot freed on the same edge
                if (done[i]) begin
                    busy_q[i]        <= 1'b0;
                    cdb_alu_o[i].tag <= slot_q[i].rob_idx;
                    case (slot_q[i].jmp_type)
                        jal: begin
                            cdb_alu_o[i].value     <= slot_q[i].curr_pc + 32'd4;
                            cdb_alu_o[i].target_pc <= target_sum[i];
                        end
                        jalr: begin
                            cdb_alu_o[i].value     <= slot_q[i].curr_pc + 32'd4;
                            cdb_alu_o[i].target_pc <= target_sum[i] & 32'hffff_fffe;
                        end
                        default: begin
                            cdb_alu_o[i].value <= alu_f[i];
                        end
                    endcase
                end
            end
        end
    end

    // one ALU per slot
    for (genvar g = 0; g < RS_SIZE; g++) begin : g_slot
        alu u_alu (
            .clk        (clk),
            .reset_i    (reset_i),
            .load_alu_i (load_alu_q[g]),
            .op_i       (slot_q[g].op),
            .a_i        (slot_q[g].rs1.value),
            .b_i        (slot_q[g].rs2.value),
            .f_o        (alu_f[g]),
            .ready_o    (alu_ready[g])
        );
    end

    // decoder must hold off while the station reports full
    assert property (@(posedge clk) disable iff (reset_i || flush_i)
        issue_i.valid |-> !rs_full_o)
        else $error("alu_rs: issue while full");

    assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(busy_q & ~$past(busy_q)))
        else $error("alu_rs: more than one slot allocated in a cycle");

endmodule

// File: design/alu_exec_cluster.sv
`timescale 1ns/1ps

module alu_exec_cluster
    import ooo_pkg::*;
#(
    parameter int RS_SIZE = 6
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  alu_rs_t                  issue_i,
    input  logic                     rob_wr_en_i,
    input  rob_tag_t                 rob_wr_idx_i,
    input  rob_data_t                rob_wr_data_i,
    input  cdb_t                     cdb_i,
    output cdb_entry_t [RS_SIZE-1:0] cdb_alu_o,
    output logic                     rs_full_o
);

    // speculative values seen by the station
    rob_arr_t rob_arr;

    rob_value_table u_rob_value_table (
        .clk       (clk),
        .reset_i   (reset_i),
        .flush_i   (flush_i),
        .wr_en_i   (rob_wr_en_i),
        .wr_idx_i  (rob_wr_idx_i),
        .wr_data_i (rob_wr_data_i),
        .rob_arr_o (rob_arr)
    );

    alu_rs #(
        .RS_SIZE (RS_SIZE)
    ) u_alu_rs (
        .clk       (clk),
        .reset_i   (reset_i),
        .flush_i   (flush_i),
        .rob_arr_i (rob_arr),
        .cdb_i     (cdb_i),
        .issue_i   (issue_i),
        .cdb_alu_o (cdb_alu_o),
        .rs_full_o (rs_full_o)
    );

endmodule

// File: sim/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: op, jmp, pc, rob_idx, rs1_tag, rs2_tag, preload, bcast
// a source tag of 0 means the operand value is given directly
// preload writes the tagged values into the ROB table before issue
// bcast sends them on the CDB after a check window
typedef struct packed {
    alu_op_t   op;
    jmp_type_t jmp;
    rv32i_word pc;
    rob_tag_t  rob_idx;
    rob_tag_t  rs1_tag;
    rob_tag_t  rs2_tag;
    logic      preload;
    logic      bcast;
} vec_t;

localparam int NUM_VECS = 16;

vec_t vectors [NUM_VECS] = '{
    '{alu_add,  none, 32'h0000_1000, 4'd1, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_sub,  none, 32'h0000_1004, 4'd2, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_sll,  none, 32'h0000_1008, 4'd3, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_slt,  none, 32'h0000_100c, 4'd4, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_sltu, none, 32'h0000_1010, 4'd5, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_xor,  none, 32'h0000_1014, 4'd6, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_srl,  none, 32'h0000_1018, 4'd7, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_sra,  none, 32'h0000_101c, 4'd1, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_or,   none, 32'h0000_1020, 4'd2, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_and,  none, 32'h0000_1024, 4'd3, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_add,  none, 32'h0000_1028, 4'd4, 4'd12, 4'd0,  1'b0, 1'b1},
    '{alu_sub,  none, 32'h0000_102c, 4'd5, 4'd13, 4'd11, 1'b0, 1'b1},
    '{alu_xor,  none, 32'h0000_1030, 4'd6, 4'd8,  4'd9,  1'b1, 1'b0},
    '{alu_sra,  none, 32'h0000_1034, 4'd7, 4'd0,  4'd10, 1'b1, 1'b0},
    '{alu_add,  jal,  32'h0000_2000, 4'd1, 4'd0,  4'd0,  1'b0, 1'b0},
    '{alu_add,  jalr, 32'h0000_3004, 4'd2, 4'd6,  4'd0,  1'b0, 1'b1}
};

string vec_names [NUM_VECS] = '{
    "add", "sub", "sll", "slt", "sltu", "xor", "srl", "sra", "or", "and",
    "rs1_cdb_wait", "both_cdb_wait", "rob_hit_both", "rob_hit_rs2", "jal", "jalr_cdb"
};

`endif

// File: sim/tb_alu_exec_cluster.sv
`timescale 1ns/1ps

module tb_alu_exec_cluster
    import ooo_pkg::*;
;

    localparam int RS_SIZE = 6;

    logic                     clk;
    logic                     reset_i;
    logic                     flush_i;
    alu_rs_t                  issue_i;
    logic                     rob_wr_en_i;
    rob_tag_t                 rob_wr_idx_i;
    rob_data_t                rob_wr_data_i;
    cdb_t                     cdb_i;
    cdb_entry_t [RS_SIZE-1:0] cdb_alu_o;
    logic                     rs_full_o;

    logic [31:0] lcg_state = 32'hd009_e627;
    int          fail_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    `include "tb_vectors.svh"

    alu_exec_cluster #(
        .RS_SIZE (RS_SIZE)
    ) DUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .issue_i       (issue_i),
        .rob_wr_en_i   (rob_wr_en_i),
        .rob_wr_idx_i  (rob_wr_idx_i),
        .rob_wr_data_i (rob_wr_data_i),
        .cdb_i         (cdb_i),
        .cdb_alu_o     (cdb_alu_o),
        .rs_full_o     (rs_full_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // reference results straight from the RV32I definitions
    function automatic rv32i_word ref_alu(alu_op_t op, rv32i_word a, rv32i_word b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 32'd1;
            alu_sll:  return a << sh;
            alu_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            alu_sltu: return {31'b0, a < b};
            alu_xor:  return a ^ b;
            alu_srl:  return a >> sh;
            // sign fill for the vacated upper bits
            alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return 32'h0;
        endcase
    endfunction

    function automatic operand_t make_operand(rob_tag_t tag, rv32i_word val);
        operand_t o;
        o.valid = (tag == '0);
        o.tag   = tag;
        o.value = (tag == '0) ? val : 32'h0;
        return o;
    endfunction

    function automatic bit find_result(input rob_tag_t tag, output cdb_entry_t e);
        e = '0;
        for (int s = 0; s < RS_SIZE; s++) begin
            if (cdb_alu_o[s].tag == tag) begin
                e = cdb_alu_o[s];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_rob(input rob_tag_t tag, input rv32i_word val);
        rob_wr_en_i              = 1'b1;
        rob_wr_idx_i             = tag;
        rob_wr_data_i.can_commit = 1'b1;
        rob_wr_data_i.value      = val;
        step();
        rob_wr_en_i = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (fail_count == errs_before) begin
            $display("%-14s passed", name);
        end else begin
            tests_failed++;
            $display("%-14s failed", name);
        end
    endtask

    task automatic run_vector(input int idx);
        vec_t       v;
        rv32i_word  a;
        rv32i_word  b;
        rv32i_word  exp_val;
        rv32i_word  exp_tgt;
        alu_rs_t    ins;
        cdb_entry_t got;
        bit         seen;
        int         errs_before;
        v           = vectors[idx];
        a           = next_rand();
        b           = next_rand();
        errs_before = fail_count;
        // odd sum so jalr really has a bit 0 to clear
        if (v.jmp == jalr) begin
            b[0] = ~a[0];
        end
        if (v.preload && v.rs1_tag != '0) write_rob(v.rs1_tag, a);
        if (v.preload && v.rs2_tag != '0) write_rob(v.rs2_tag, b);
        ins          = '0;
        ins.valid    = 1'b1;
        ins.op       = v.op;
        ins.jmp_type = v.jmp;
        ins.curr_pc  = v.pc;
        ins.rob_idx  = v.rob_idx;
        ins.rs1      = make_operand(v.rs1_tag, a);
        ins.rs2      = make_operand(v.rs2_tag, b);
        issue_i      = ins;
        step();
        issue_i = '0;
        if (v.bcast) begin
            // nothing may come out while an operand is still pending
            for (int c = 0; c < 5; c++) begin
                step();
                if (find_result(v.rob_idx, got)) begin
                    $display("%s: result for tag %0d appeared before the broadcast",
                             vec_names[idx], v.rob_idx);
                    fail_count++;
                end
            end
            cdb_i[0].tag   = v.rs1_tag;
            cdb_i[0].value = a;
            cdb_i[1].tag   = v.rs2_tag;
            cdb_i[1].value = b;
            step();
            cdb_i = '0;
        end
        seen = 1'b0;
        for (int c = 0; c < 20 && !seen; c++) begin
            step();
            seen = find_result(v.rob_idx, got);
        end
        if (v.jmp == none) begin
            exp_val = ref_alu(v.op, a, b);
            exp_tgt = 32'h0;
        end else begin
            exp_val = v.pc + 32'd4;
            exp_tgt = a + b;
            if (v.jmp == jalr) exp_tgt[0] = 1'b0;
        end
        if (!seen) begin
            $display("%s: timed out waiting for a result with tag %0d",
                     vec_names[idx], v.rob_idx);
            fail_count++;
        end else begin
            if (got.value != exp_val) begin
                $display("FAILED %s value expected %h actual %h",
                         vec_names[idx], exp_val, got.value);
                fail_count++;
            end
            if (v.jmp != none && got.target_pc != exp_tgt) begin
                $display("FAILED %s target expected %h actual %h",
                         vec_names[idx], exp_tgt, got.target_pc);
                fail_count++;
            end
        end
        finish_test(vec_names[idx], errs_before);
    endtask

    // fill every slot with pending work, then flush it away
    task automatic run_flush_test();
        alu_rs_t ins;
        int      c;
        int      errs_before;
        errs_before = fail_count;
        for (int k = 0; k < RS_SIZE; k++) begin
            if (rs_full_o) begin
                $display("flush: rs_full_o was high before the station filled");
                fail_count++;
            end
            ins         = '0;
            ins.valid   = 1'b1;
            ins.op      = alu_add;
            ins.rob_idx = rob_tag_t'(k + 1);
            ins.rs1     = make_operand(4'd14, 32'h0);
            ins.rs2     = make_operand(4'd0, next_rand());
            issue_i     = ins;
            step();
        end
        issue_i = '0;
        c = 0;
        while (!rs_full_o && c < 10) begin
            step();
            c++;
        end
        if (!rs_full_o) begin
            $display("flush: rs_full_o never rose with every slot waiting");
            fail_count++;
        end
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
        c = 0;
        while (rs_full_o && c < 10) begin
            step();
            c++;
        end
        if (rs_full_o) begin
            $display("flush: rs_full_o stayed high after the flush");
            fail_count++;
        end
        cdb_i[0].tag   = 4'd14;
        cdb_i[0].value = next_rand();
        step();
        cdb_i = '0;
        for (c = 0; c < 8; c++) begin
            for (int s = 0; s < RS_SIZE; s++) begin
                if (cdb_alu_o[s].tag != '0) begin
                    $display("flush: slot %0d produced a result after the flush", s);
                    fail_count++;
                end
            end
            step();
        end
        finish_test("flush", errs_before);
    endtask

    initial begin
        reset_i       = 1'b1;
        flush_i       = 1'b0;
        issue_i       = '0;
        rob_wr_en_i   = 1'b0;
        rob_wr_idx_i  = '0;
        rob_wr_data_i = '0;
        cdb_i         = '0;
        repeat (2) @(posedge clk);
        #1;
        reset_i = 1'b0;
        for (int i = 0; i < NUM_VECS; i++) begin
            run_vector(i);
        end
        run_flush_test();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: alu_exec_cluster.f
+incdir+sim
design/ooo_pkg.sv
design/alu.sv
design/rob_value_table.sv
design/alu_rs.sv
design/alu_exec_cluster.sv
sim/tb_alu_exec_cluster.sv
